//--- src/dcache_defs.svh
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// cache geometry
`define DC_SETS   8
`define DC_WAYS   2

`define DC_WORD_W 32   // data and address word

// address split, tag + index + block offset + 2 byte bits
`define DC_IDX_W  3
`define DC_BLK_W  1
`define DC_TAG_W  26

`endif

//--- src/dcache_addr_pkg.sv
`default_nettype none

`include "dcache_defs.svh"

package dcache_addr_pkg;

   typedef logic [`DC_WORD_W-1:0] word_t;

   typedef logic [`DC_TAG_W-1:0] dc_tag_t;
   typedef logic [`DC_IDX_W-1:0] dc_idx_t;
   typedef logic [`DC_BLK_W-1:0] dc_blk_t;

   // field view, msb first
   typedef struct packed {
      dc_tag_t    tag;
      dc_idx_t    idx;
      dc_blk_t    blk;
      logic [1:0] byt;   // byte offset, ignored by the cache
   } dc_addr_f_t;

   typedef union packed {
      word_t      word;
      dc_addr_f_t f;
   } dc_addr_u;

endpackage

`default_nettype wire

//--- src/dcache_line_pkg.sv
`default_nettype none

`include "dcache_defs.svh"

package dcache_line_pkg;
   import dcache_addr_pkg::*;

   // one block, 92 bits
   typedef struct packed {
      logic    valid;
      logic    dirty;
      dc_tag_t tag;
      word_t [(1 << `DC_BLK_W)-1:0] data;
   } dc_line_t;

   typedef logic dc_way_t;

   typedef enum logic [2:0] {
      IDLE,
      WB0,     // victim word 0 to memory
      WB1,
      FILL0,   // requested word
      FILL1,   // other word of the block
      FLUSH,
      DONE
   } dc_state_t;

endpackage

`default_nettype wire

//--- src/dcache_tag_if.sv
`timescale 1ns/100ps
`default_nettype none

// tag state of the set being looked up
interface dcache_tag_if import dcache_addr_pkg::*; ();

   dc_idx_t idx;        // set under lookup

   logic    valid0;
   logic    dirty0;
   dc_tag_t tag0;

   logic    valid1;
   logic    dirty1;
   dc_tag_t tag1;

   modport store (
      input  idx,
      output valid0, dirty0, tag0, valid1, dirty1, tag1
   );

   modport lookup (
      output idx,
      input  valid0, dirty0, tag0, valid1, dirty1, tag1
   );

endinterface

`default_nettype wire

//--- src/dcache_update_if.sv
`timescale 1ns/100ps
`default_nettype none

interface dcache_update_if import dcache_addr_pkg::*; import dcache_line_pkg::*; ();

   logic    wr;            // apply update at next edge
   dc_way_t way;           // hit way, used unless filling
   dc_idx_t idx;
   dc_blk_t word_sel;
   word_t   data;
   dc_tag_t fill_tag;
   logic    set_dirty;
   logic    set_valid;     // also loads fill_tag
   logic    clear_dirty;
   logic    fill;          // request served from the victim way

   modport ctrl (
      output wr, way, idx, word_sel, data, fill_tag,
             set_dirty, set_valid, clear_dirty, fill
   );

   modport store (
      input  wr, way, idx, word_sel, data, fill_tag,
             set_dirty, set_valid, clear_dirty, fill
   );

endinterface

`default_nettype wire

//--- src/dcache_lookup.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_lookup
   import dcache_addr_pkg::*;
   import dcache_line_pkg::*;
(
   input  logic         CLK,
   input  logic         nRST,
   input  dc_addr_u     req_addr,
   dcache_tag_if.lookup tag,
   input  logic         touch,
   input  dc_way_t      touch_way,
   output logic         hit,
   output dc_way_t      hit_way,
   output dc_way_t      victim_way,
   output logic         victim_dirty,
   output dc_tag_t      victim_tag
);

   logic [`DC_SETS-1:0] lru;   // per set, the way to evict next
   logic hit0;
   logic hit1;

   assign tag.idx = req_addr.f.idx;

   assign hit0 = tag.valid0 && (tag.tag0 == req_addr.f.tag);
   assign hit1 = tag.valid1 && (tag.tag1 == req_addr.f.tag);
   assign hit = hit0 | hit1;
   assign hit_way = dc_way_t'(hit1);

   assign victim_way = lru[req_addr.f.idx];
   // an invalid victim never needs a write-back
   assign victim_dirty = victim_way ? (tag.valid1 && tag.dirty1) : (tag.valid0 && tag.dirty0);
   assign victim_tag = victim_way ? tag.tag1 : tag.tag0;

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
         lru <= '0;
      else if (touch)
         lru[req_addr.f.idx] <= ~touch_way;   // other way becomes the victim
   end

   // a fill must never leave the same block in both ways
   a_one_way_hit : assert property (@(posedge CLK) disable iff (!nRST)
      !(hit0 && hit1));

endmodule

`default_nettype wire

//--- src/dcache_controller.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_controller
   import dcache_addr_pkg::*;
   import dcache_line_pkg::*;
(
   input  logic                CLK,
   input  logic                nRST,
   input  dc_addr_u            req_addr,
   input  logic                dmemREN,
   input  logic                dmemWEN,
   input  word_t               dmemstore,
   input  logic                halt,
   output logic                dhit,
   output logic                flushed,
   output logic                dREN,
   output logic                dWEN,
   output word_t               daddr,
   output word_t               dstore,
   input  word_t               dload,
   input  logic                dwait,
   input  logic                hit,
   input  dc_way_t             hit_way,
   input  dc_way_t             victim_way,
   input  logic                victim_dirty,
   input  dc_tag_t             victim_tag,
   output logic                touch,
   output dc_way_t             touch_way,
   dcache_update_if.ctrl       up,
   input  dc_line_t            victim_data,
   input  dc_line_t            flush_line,
   output logic [`DC_IDX_W:0]  flush_sel
);

   dc_state_t state;
   dc_state_t next_state;

   // {end flag, way, index} of the flush walk
   logic [`DC_IDX_W+1:0] fl_cnt;
   dc_blk_t fl_word;
   logic fl_dirty;
   logic req;
   dc_addr_u mem_addr;

   assign req = dmemREN | dmemWEN;
   assign fl_dirty = flush_line.valid & flush_line.dirty;
   assign flush_sel = fl_cnt[`DC_IDX_W:0];
   assign flushed = (state == DONE);
   assign daddr = mem_addr.word;

   assign up.way = hit_way;
   assign up.idx = req_addr.f.idx;
   assign up.fill_tag = req_addr.f.tag;
   assign up.fill = (state == FILL0) || (state == FILL1);

   always_comb
   begin
      next_state = state;
      dhit = 1'b0;
      dREN = 1'b0;
      dWEN = 1'b0;
      dstore = '0;
      touch = 1'b0;
      touch_way = hit_way;
      mem_addr.f.tag = req_addr.f.tag;
      mem_addr.f.idx = req_addr.f.idx;
      mem_addr.f.blk = req_addr.f.blk;
      mem_addr.f.byt = 2'b00;
      up.wr = 1'b0;
      up.word_sel = req_addr.f.blk;
      up.data = dmemstore;
      up.set_valid = 1'b0;
      up.set_dirty = 1'b0;
      up.clear_dirty = 1'b0;

      case (state)
         IDLE:
         begin
            if (halt)
               next_state = FLUSH;
            else if (req && hit)
            begin
               dhit = 1'b1;
               touch = 1'b1;
               up.wr = dmemWEN;   // write hit lands at next edge
               up.set_dirty = 1'b1;
            end
            else if (req)
               next_state = victim_dirty ? WB0 : FILL0;
         end
         WB0, WB1:
         begin
            dWEN = 1'b1;
            mem_addr.f.tag = victim_tag;
            mem_addr.f.blk = (state == WB1);
            dstore = victim_data.data[state == WB1];
            if (!dwait)
               next_state = (state == WB0) ? WB1 : FILL0;
         end
         FILL0:
         begin
            dREN = 1'b1;
            if (!dwait)
            begin
               up.wr = 1'b1;
               up.set_valid = 1'b1;
               up.set_dirty = dmemWEN;
               up.clear_dirty = !dmemWEN;
               up.data = dmemWEN ? dmemstore : dload;   // write miss keeps the core word
               next_state = FILL1;
            end
         end
         FILL1:
         begin
            dREN = 1'b1;
            mem_addr.f.blk = ~req_addr.f.blk;
            up.word_sel = ~req_addr.f.blk;
            if (!dwait)
            begin
               up.wr = 1'b1;
               up.data = dload;
               dhit = 1'b1;
               touch = 1'b1;
               touch_way = victim_way;
               next_state = IDLE;
            end
         end
         FLUSH:
         begin
            mem_addr.f.tag = flush_line.tag;
            mem_addr.f.idx = fl_cnt[`DC_IDX_W-1:0];
            mem_addr.f.blk = fl_word;
            dstore = flush_line.data[fl_word];
            if (fl_cnt[`DC_IDX_W+1])
               next_state = DONE;   // both ways walked
            else
               dWEN = fl_dirty;
         end
         DONE: ;
         default:
            next_state = IDLE;
      endcase
   end

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         state <= IDLE;
         fl_cnt <= '0;
         fl_word <= '0;
      end
      else
      begin
         state <= next_state;
         if (state == FLUSH && !fl_cnt[`DC_IDX_W+1])
         begin
            if (!fl_dirty)
               fl_cnt <= fl_cnt + 1'b1;   // skip a clean line
            else if (!dwait)
            begin
               fl_word <= ~fl_word;
               if (fl_word)
                  fl_cnt <= fl_cnt + 1'b1;
            end
         end
      end
   end

   // memory side holds still while a transfer waits
   a_hold_on_wait : assert property (@(posedge CLK) disable iff (!nRST)
      (dREN || dWEN) && dwait |=> $stable(state) && $stable(daddr) && $stable(dstore));

   a_flush_end : assert property (@(posedge CLK) disable iff (!nRST)
      flushed |-> (fl_cnt == `DC_SETS * `DC_WAYS));   // walk covered every line

endmodule

`default_nettype wire

//--- src/dcache_store.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_store
   import dcache_addr_pkg::*;
   import dcache_line_pkg::*;
(
   input  logic               CLK,
   input  logic               nRST,
   input  dc_addr_u           req_addr,
   input  dc_way_t            victim_way,
   input  logic [`DC_IDX_W:0] flush_sel,   // {way, index}
   dcache_tag_if.store        tag,
   dcache_update_if.store     up,
   output word_t              dmemload,
   output dc_line_t           victim_data,
   output dc_line_t           flush_line
);

   logic [`DC_WAYS-1:0][`DC_SETS-1:0] valid_q;
   logic [`DC_WAYS-1:0][`DC_SETS-1:0] dirty_q;
   dc_tag_t tag_q  [`DC_WAYS][`DC_SETS];
   word_t   data_q [`DC_WAYS][`DC_SETS][1 << `DC_BLK_W];
   dc_way_t tgt_way;

   function automatic dc_line_t get_line(dc_way_t w, dc_idx_t i);
      dc_line_t l;
      l.valid = valid_q[w][i];
      l.dirty = dirty_q[w][i];
      l.tag = tag_q[w][i];
      l.data[0] = data_q[w][i][0];
      l.data[1] = data_q[w][i][1];
      return l;
   endfunction

   // fills go to the victim way
   assign tgt_way = up.fill ? victim_way : up.way;

   assign tag.valid0 = valid_q[0][tag.idx];
   assign tag.dirty0 = dirty_q[0][tag.idx];
   assign tag.tag0 = tag_q[0][tag.idx];
   assign tag.valid1 = valid_q[1][tag.idx];
   assign tag.dirty1 = dirty_q[1][tag.idx];
   assign tag.tag1 = tag_q[1][tag.idx];

   always_comb
   begin
      victim_data = get_line(victim_way, req_addr.f.idx);
      flush_line = get_line(dc_way_t'(flush_sel[`DC_IDX_W]), flush_sel[`DC_IDX_W-1:0]);
      dmemload = data_q[tgt_way][req_addr.f.idx][req_addr.f.blk];
   end

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         valid_q <= '0;
         dirty_q <= '0;
      end
      else if (up.wr)
      begin
         if (up.set_valid)
            valid_q[tgt_way][up.idx] <= 1'b1;
         if (up.set_dirty)
            dirty_q[tgt_way][up.idx] <= 1'b1;
         else if (up.clear_dirty)
            dirty_q[tgt_way][up.idx] <= 1'b0;
      end
   end

   always_ff @(posedge CLK)
   begin
      if (up.wr)
      begin
         data_q[tgt_way][up.idx][up.word_sel] <= up.data;
         if (up.set_valid)
            tag_q[tgt_way][up.idx] <= up.fill_tag;
      end
   end

   // only a tag load may write a line that is not yet valid
   a_update_target : assert property (@(posedge CLK) disable iff (!nRST)
      up.wr |-> !$isunknown({tgt_way, up.idx, up.word_sel})
                && (up.set_valid || valid_q[tgt_way][up.idx]));

endmodule

`default_nettype wire

//--- src/dcache_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_top
   import dcache_addr_pkg::*;
   import dcache_line_pkg::*;
(
   input  logic  CLK,
   input  logic  nRST,
   // core side
   input  logic  dmemREN,
   input  logic  dmemWEN,
   input  word_t dmemaddr,
   input  word_t dmemstore,
   input  logic  halt,
   output logic  dhit,
   output word_t dmemload,
   output logic  flushed,
   // memory side
   output logic  dREN,
   output logic  dWEN,
   output word_t daddr,
   output word_t dstore,
   input  word_t dload,
   input  logic  dwait
);

   dc_addr_u req_addr;
   logic hit;
   logic victim_dirty;
   logic touch;
   dc_way_t hit_way;
   dc_way_t victim_way;
   dc_way_t touch_way;
   dc_tag_t victim_tag;
   dc_line_t victim_data;
   dc_line_t flush_line;
   logic [`DC_IDX_W:0] flush_sel;

   dcache_tag_if    tag_if ();
   dcache_update_if up_if ();

   assign req_addr.word = dmemaddr;

   dcache_lookup u_lookup (.tag(tag_if), .*);

   dcache_controller u_ctrl (.up(up_if), .*);

   dcache_store u_store (.tag(tag_if), .up(up_if), .*);

endmodule

`default_nettype wire

//--- verification/dcache_tb.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_tb
   import dcache_addr_pkg::*;
();

   localparam int TIMEOUT  = 200;   // cycles per wait
   localparam int N_RANDOM = 200;
   localparam int N_WORDS  = 64;    // 4 tags x 8 sets x 2 words

   logic  CLK;
   logic  nRST;
   logic  dmemREN;
   logic  dmemWEN;
   word_t dmemaddr;
   word_t dmemstore;
   logic  halt;
   logic  dhit;
   word_t dmemload;
   logic  flushed;
   logic  dREN;
   logic  dWEN;
   word_t daddr;
   word_t dstore;
   word_t dload;
   logic  dwait;

   integer seed = 26118;
   word_t  mem     [N_WORDS];   // memory behind the cache
   word_t  ref_mem [N_WORDS];   // last value written by the core
   logic   written [N_WORDS];
   word_t  wlog_addr [$];       // memory writes in order
   word_t  wlog_data [$];
   logic   busy;
   int     wait_left;
   int     err_cnt;
   int     check_cnt;
   int     tests_run;
   int     tests_failed;

   dcache_top DUT (
      .CLK(CLK), .nRST(nRST),
      .dmemREN(dmemREN), .dmemWEN(dmemWEN), .dmemaddr(dmemaddr),
      .dmemstore(dmemstore), .halt(halt), .dhit(dhit),
      .dmemload(dmemload), .flushed(flushed),
      .dREN(dREN), .dWEN(dWEN), .daddr(daddr), .dstore(dstore),
      .dload(dload), .dwait(dwait)
   );

   initial
   begin
      CLK = 1'b0;
      forever #10 CLK = ~CLK;
   end

   // memory model with a new random wait per transfer
   always @(negedge CLK)
   begin
      if (dREN || dWEN)
      begin
         if (!busy)
         begin
            busy = 1'b1;
            wait_left = $unsigned($random(seed)) % 4;
         end
         dwait = (wait_left != 0);
         if (wait_left != 0)
            wait_left = wait_left - 1;
         if (dREN)
            dload = mem[daddr[7:2]];
      end
      else
      begin
         busy = 1'b0;
         dwait = 1'b0;
      end
   end

   always @(posedge CLK)
   begin
      if ((dREN || dWEN) && !dwait)
      begin
         busy = 1'b0;   // transfer done at this edge
         if (dWEN)
         begin
            mem[daddr[7:2]] = dstore;
            wlog_addr.push_back(daddr);
            wlog_data.push_back(dstore);
         end
      end
   end

   function automatic int urand(int n);
      return $unsigned($random(seed)) % n;
   endfunction

   function automatic word_t make_addr(int t, int i, int b);
      dc_addr_u a;
      a.f.tag = dc_tag_t'(t);
      a.f.idx = dc_idx_t'(i);
      a.f.blk = dc_blk_t'(b);
      a.f.byt = 2'b00;
      return a.word;
   endfunction

   task automatic check(input logic ok, input string msg);
      check_cnt++;
      assert (ok)
      else
      begin
         $display("[FAIL] %0t ns: %s", $time, msg);
         err_cnt++;
      end
   endtask

   task automatic model_write(input word_t addr, input word_t data);
      ref_mem[addr[7:2]] = data;
      written[addr[7:2]] = 1'b1;
   endtask

   task automatic report_test(input string name, input int err_before);
      tests_run++;
      if (err_cnt != err_before)
         tests_failed++;
      $display("test %0d %s: %s", tests_run, name, (err_cnt == err_before) ? "ok" : "errors");
   endtask

   // one core request held until dhit
   task automatic access(input logic wr, input word_t addr, input word_t wdata,
                         output word_t rdata, output int cycles, output logic mem_act);
      logic got;
      got = 1'b0;
      cycles = 0;
      rdata = '0;
      mem_act = 1'b0;
      @(negedge CLK);
      dmemREN = !wr;
      dmemWEN = wr;
      dmemaddr = addr;
      dmemstore = wdata;
      while (!got && cycles < TIMEOUT)
      begin
         @(posedge CLK);
         cycles++;
         if (dhit)
         begin
            got = 1'b1;
            rdata = dmemload;
            mem_act = dREN | dWEN;
         end
      end
      if (!got)
      begin
         $display("timeout: no dhit within %0d cycles for address %h", TIMEOUT, addr);
         $display("Result: FAILED");
         $finish;
      end
      else
      begin
         @(negedge CLK);
         dmemREN = 1'b0;   // drop before the line hits again
         dmemWEN = 1'b0;
      end
   endtask

   initial
   begin
      word_t addr;
      word_t wdata;
      word_t rdata;
      word_t a_addr;
      logic  wr;
      logic  mem_act;
      logic  got;
      logic  stay;
      int    cycles;
      int    err0;
      int    tag_a;
      int    tag_b;
      int    tag_c;

      nRST = 1'b0;
      dmemREN = 1'b0;
      dmemWEN = 1'b0;
      dmemaddr = '0;
      dmemstore = '0;
      halt = 1'b0;
      dload = '0;
      dwait = 1'b0;
      busy = 1'b0;
      wait_left = 0;
      for (int i = 0; i < N_WORDS; i++)
      begin
         mem[i] = '0;
         ref_mem[i] = '0;
         written[i] = 1'b0;
      end
      repeat (5) @(posedge CLK);
      @(negedge CLK);
      nRST = 1'b1;

      err0 = err_cnt;
      @(posedge CLK);
      check(!dREN && !dWEN && !dhit && !flushed, "outputs not idle after reset");
      report_test("reset state", err0);

      err0 = err_cnt;
      for (int n = 0; n < N_RANDOM; n++)
      begin
         addr = make_addr(urand(4), urand(8), urand(2));
         wr = urand(2);
         wdata = $random(seed);
         access(wr, addr, wdata, rdata, cycles, mem_act);
         if (wr)
            model_write(addr, wdata);
         else
            check(rdata === ref_mem[addr[7:2]], $sformatf("read %h gave %h, expected %h",
                  addr, rdata, ref_mem[addr[7:2]]));
      end
      report_test("random access", err0);

      err0 = err_cnt;
      for (int n = 0; n < 16; n++)
      begin
         addr = make_addr(urand(4), urand(8), urand(2));
         wr = urand(2);
         wdata = $random(seed);
         access(wr, addr, wdata, rdata, cycles, mem_act);
         if (wr)
            model_write(addr, wdata);
         access(1'b0, addr, '0, rdata, cycles, mem_act);
         check(cycles == 1 && !mem_act, $sformatf("repeat of %h took %0d cycles", addr, cycles));
         check(rdata === ref_mem[addr[7:2]], $sformatf("repeat read %h gave %h, expected %h",
               addr, rdata, ref_mem[addr[7:2]]));
      end
      report_test("repeat hit", err0);

      err0 = err_cnt;
      for (int s = 0; s < 8; s++)
      begin
         tag_a = urand(4);
         tag_b = (tag_a + 1 + urand(3)) % 4;
         tag_c = (tag_a + 1) % 4;
         if (tag_c == tag_b)
            tag_c = (tag_a + 2) % 4;
         a_addr = make_addr(tag_a, s, 0);
         wdata = $random(seed);
         access(1'b1, a_addr, wdata, rdata, cycles, mem_act);
         model_write(a_addr, wdata);
         addr = make_addr(tag_b, s, urand(2));
         access(1'b1, addr, $random(seed), rdata, cycles, mem_act);
         model_write(addr, dmemstore);
         wlog_addr.delete();
         wlog_data.delete();
         addr = make_addr(tag_c, s, urand(2));
         access(1'b0, addr, '0, rdata, cycles, mem_act);
         check(rdata === ref_mem[addr[7:2]], $sformatf("read %h gave %h, expected %h",
               addr, rdata, ref_mem[addr[7:2]]));
         check(wlog_addr.size() > 0 && wlog_addr[0] === a_addr && wlog_data[0] === wdata,
               $sformatf("set %0d: first write-back is not %h/%h", s, a_addr, wdata));
      end
      report_test("lru victim", err0);

      err0 = err_cnt;
      @(negedge CLK);
      halt = 1'b1;
      got = 1'b0;
      cycles = 0;
      while (!got && cycles < TIMEOUT)
      begin
         @(posedge CLK);
         cycles++;
         got = flushed;
      end
      if (!got)
      begin
         $display("timeout: flushed did not rise within %0d cycles", TIMEOUT);
         err_cnt++;
      end
      else
      begin
         stay = 1'b1;
         repeat (10)
         begin
            @(posedge CLK);
            if (!flushed)
               stay = 1'b0;
         end
         check(stay, "flushed dropped after rising");
         for (int i = 0; i < N_WORDS; i++)
            if (written[i])
               check(mem[i] === ref_mem[i], $sformatf("memory word %0d is %h, expected %h",
                     i, mem[i], ref_mem[i]));
      end
      report_test("halt flush", err0);

      $display("tests: %0d run, %0d failed; checks: %0d, errors: %0d",
               tests_run, tests_failed, check_cnt, err_cnt);
      if (err_cnt == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- flist.f
+incdir+src
src/dcache_addr_pkg.sv
src/dcache_line_pkg.sv
src/dcache_tag_if.sv
src/dcache_update_if.sv
src/dcache_lookup.sv
src/dcache_controller.sv
src/dcache_store.sv
src/dcache_top.sv
verification/dcache_tb.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - include_dirs:
      - src
    files:
      - src/dcache_addr_pkg.sv
      - src/dcache_line_pkg.sv
      - src/dcache_tag_if.sv
      - src/dcache_update_if.sv
      - src/dcache_lookup.sv
      - src/dcache_controller.sv
      - src/dcache_store.sv
      - src/dcache_top.sv
  - target: test
    files:
      - verification/dcache_tb.sv
